//--- all.f
+incdir+verilog
verilog/boot_pkg.sv
verilog/boot_ifs.sv
verilog/boot_fsm.sv
verilog/block_counter.sv
verilog/data_mem.sv
verilog/instr_mem.sv
verilog/boot_top.sv
tb/tb_boot_top.sv

//--- run.sh
#!/bin/sh
# compile and run the boot loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_boot_top -Mdir obj_dir -o tb_boot_top -f all.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_boot_top > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

//--- tb/tb_boot_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "boot_defs.svh"

module tb_boot_top import boot_pkg::*; ();

    // 65 blocks at up to 23 cycles, 769 fetch cycles, 18 line reads, reset, margin
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int LW = `BOOT_LINE_WORDS;
    localparam int DM_WORDS = `BOOT_DM_BLOCKS * `BOOT_LINE_WORDS;
    localparam int IM_WORDS = `BOOT_IM_BLOCKS * `BOOT_LINE_WORDS;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     ready, rd_valid, tx_done;
    word_t    ex_wrt_data;
    host_op_t op;
    ex_addr_t ex_addr;
    logic     running;
    addr_t    fetch_addr;
    word_t    fetch_instr;
    addr_t    accel_addr;
    word_t    accel_wrt_data;
    logic     accel_wrt_en, accel_rd_en, accel_wrt_done, accel_rd_valid;
    line_t    accel_rd_data;

    // data block bases, pairs 0x40 apart from 0x1000, last block low
    addr_t dm_base_tab [0:`BOOT_DM_BLOCKS-1] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140, 16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140, 16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100
    };

    word_t       dm_img [0:DM_WORDS-1];    // expected images
    word_t       im_img [0:IM_WORDS-1];
    logic [31:0] lfsr = 32'h33ac8c24;
    int          err_count = 0;
    int          early_resp = 0;            // responses seen before running
    int          cycles = 0;

    boot_top u_boot_top (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // galois step
        end
        return v;
    endfunction

    function automatic line_t expected_line(input int b);
        line_t l;
        for (int i = 0; i < LW; i++) begin
            l[i*`BOOT_WORD_W +: `BOOT_WORD_W] = dm_img[b*LW + i];
        end
        return l;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_op(input string name, input host_op_t got, input host_op_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_ex_addr(input string name, input ex_addr_t got, input ex_addr_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic report(input int num, input string name, input int errs);
        if (errs == 0) $display("test %0d %s: ok", num, name);
        else           $display("test %0d %s: %0d errors", num, name, errs);
    endtask

    // accelerator strobes must stay quiet while loading
    task automatic check_quiet();
        int e0;
        e0 = err_count;
        check_bit("accel_rd_valid", accel_rd_valid, 1'b0);
        check_bit("accel_wrt_done", accel_wrt_done, 1'b0);
        early_resp += err_count - e0;
    endtask

    //////////////////////////////////////////////////
    // host model, one 64-byte block per request
    //////////////////////////////////////////////////
    task automatic serve_block(input logic im, input int idx);
        int       gap;
        word_t    w;
        ex_addr_t exp_addr;
        exp_addr = ex_addr_t'(im ? addr_t'(idx * 64) : dm_base_tab[idx]);
        if (im) exp_addr[`BOOT_IM_SELECT_BIT] = 1'b1;
        gap = int'(rand_bits(3));
        @(negedge clk);
        check_op("op", op, READ);
        check_ex_addr("ex_addr", ex_addr, exp_addr);
        check_bit("running", running, 1'b0);
        repeat (gap) begin
            @(posedge clk);
            @(negedge clk);
            check_op("op", op, READ);
            check_quiet();
        end
        for (int i = 0; i < LW; i++) begin
            w = rand_bits(32);
            if (im) im_img[idx*LW + i] = w;
            else    dm_img[idx*LW + i] = w;
            @(posedge clk);
            rd_valid    <= (i == 0);        // word 0 ends the wait
            tx_done     <= (i == LW - 1);
            ex_wrt_data <= w;
            @(negedge clk);
            check_quiet();
        end
        @(posedge clk);
        tx_done <= 1'b0;
        if (im && idx == `BOOT_IM_BLOCKS - 1) begin
            accel_rd_en  <= 1'b0;           // drop before running rises
            accel_wrt_en <= 1'b0;
        end
    endtask

    task automatic read_line(input addr_t a, input line_t exp);
        @(posedge clk);
        accel_addr  <= a;
        accel_rd_en <= 1'b1;
        @(posedge clk);
        accel_rd_en <= 1'b0;
        @(negedge clk);
        check_bit("accel_rd_valid", accel_rd_valid, 1'b1);
        check_line("accel_rd_data", accel_rd_data, exp);
        @(posedge clk);
        @(negedge clk);
        check_bit("accel_rd_valid", accel_rd_valid, 1'b0);  // single pulse
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic test_reset();
        int e0;
        e0 = err_count;
        repeat (10) begin
            @(posedge clk);
            @(negedge clk);
            check_op("op", op, IDLE);
            check_ex_addr("ex_addr", ex_addr, '0);
            check_bit("running", running, 1'b0);
            check_bit("accel_rd_valid", accel_rd_valid, 1'b0);
            check_bit("accel_wrt_done", accel_wrt_done, 1'b0);
        end
        report(1, "reset values", err_count - e0);
    endtask

    task automatic test_load();
        int e0;
        e0 = err_count;
        @(posedge clk);
        ready          <= 1'b1;
        accel_addr     <= 16'h1000;
        accel_wrt_data <= rand_bits(32);
        accel_rd_en    <= 1'b1;         // held through the load
        accel_wrt_en   <= 1'b1;
        @(posedge clk);                 // fsm samples ready
        for (int b = 0; b < `BOOT_DM_BLOCKS; b++) serve_block(1'b0, b);
        for (int b = 0; b < `BOOT_IM_BLOCKS; b++) serve_block(1'b1, b);
        @(negedge clk);
        check_bit("running", running, 1'b1);
        check_op("op", op, IDLE);
        check_ex_addr("ex_addr", ex_addr, '0);
        report(2, "load sequence", err_count - e0 - early_resp);
        report(6, "early accelerator requests", early_resp);
    endtask

    task automatic test_fetch();
        int e0;
        e0 = err_count;
        for (int a = 0; a <= IM_WORDS; a++) begin
            @(posedge clk);
            if (a < IM_WORDS) fetch_addr <= addr_t'(a * 4);
            @(negedge clk);
            if (a > 0) check_word("fetch_instr", fetch_instr, im_img[a-1]);
        end
        report(3, "fetch readback", err_count - e0);
    endtask

    task automatic test_line_read();
        int e0;
        e0 = err_count;
        for (int b = 0; b < `BOOT_DM_BLOCKS; b++) read_line(dm_base_tab[b], expected_line(b));
        report(4, "accelerator line read", err_count - e0);
    endtask

    task automatic test_write();
        int    e0;
        int    b;
        int    w;
        word_t val;
        e0  = err_count;
        b   = int'(rand_bits(4));
        w   = int'(rand_bits(4));
        val = rand_bits(32);
        @(posedge clk);
        accel_addr     <= dm_base_tab[b] + addr_t'(w * 4);
        accel_wrt_data <= val;
        accel_wrt_en   <= 1'b1;
        @(posedge clk);
        accel_wrt_en <= 1'b0;
        @(negedge clk);
        check_bit("accel_wrt_done", accel_wrt_done, 1'b1);
        @(posedge clk);
        @(negedge clk);
        check_bit("accel_wrt_done", accel_wrt_done, 1'b0);
        dm_img[b*LW + w] = val;
        read_line(dm_base_tab[b], expected_line(b));
        report(5, "accelerator write", err_count - e0);
    endtask

    initial begin
        rst_n          <= 1'b0;
        ready          <= 1'b0;
        rd_valid       <= 1'b0;
        tx_done        <= 1'b0;
        ex_wrt_data    <= '0;
        fetch_addr     <= '0;
        accel_addr     <= '0;
        accel_wrt_data <= '0;
        accel_wrt_en   <= 1'b0;
        accel_rd_en    <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_load();
        test_fetch();
        test_line_read();
        test_write();
        $display("6 tests done, %0d errors, %0d early responses", err_count, early_resp);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/block_counter.sv
`timescale 1ns/10ps
`default_nettype none
`include "boot_defs.svh"

module block_counter import boot_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    load_ctl_if.cnt   ctl,
    output ex_addr_t  ex_addr
);

    blk_idx_t idx_q;
    blk_idx_t blk;          // effective index this cycle
    addr_t    addr_q;       // address of the last word written
    addr_t    base;
    logic     im_phase_q;
    logic     im_rise;

    assign im_rise = ctl.im_phase && !im_phase_q;
    assign blk     = im_rise ? '0 : idx_q;      // restart at block 0 for the instruction image

    assign base = ctl.im_phase ? im_block_base(blk) : dm_block_base(blk);

    assign ctl.last_block = ctl.im_phase ? (blk == blk_idx_t'(`BOOT_IM_BLOCKS - 1))
                                         : (blk == blk_idx_t'(`BOOT_DM_BLOCKS - 1));

    assign ctl.load_addr = ctl.first_word ? base : addr_q + addr_t'(4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q      <= '0;
            addr_q     <= '0;
            im_phase_q <= 1'b0;
        end else begin
            im_phase_q <= ctl.im_phase;
            if (ctl.next_block) idx_q <= blk + blk_idx_t'(1);
            else                idx_q <= blk;
            if (ctl.first_word || ctl.step) addr_q <= ctl.load_addr;
        end
    end

    // host address, bit 16 picks the instruction image
    always_comb begin
        ex_addr = '0;
        if (ctl.loading) begin
            ex_addr = ex_addr_t'(base);
            ex_addr[`BOOT_IM_SELECT_BIT] = ctl.im_phase;
        end
    end

    a_idx_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctl.loading |-> (ctl.im_phase ? (blk <= blk_idx_t'(`BOOT_IM_BLOCKS - 1))
                                      : (blk <= blk_idx_t'(`BOOT_DM_BLOCKS - 1)))
    );

endmodule

`default_nettype wire

//--- verilog/boot_defs.svh
`ifndef BOOT_DEFS_SVH
`define BOOT_DEFS_SVH

// bus widths
`define BOOT_ADDR_W         16  // byte address
`define BOOT_WORD_W         32  // data / instruction word
`define BOOT_EX_ADDR_W      64  // host address

// one 64-byte block is 16 words
`define BOOT_LINE_WORDS     16

// block counts per image
`define BOOT_DM_BLOCKS      17
`define BOOT_IM_BLOCKS      48

// memory depths as word index widths
`define BOOT_DM_INDEX_W     13  // 8192 words, bytes up to 0x7fff
`define BOOT_IM_INDEX_W     10  // 1024 words

// host address bit that marks the instruction image
`define BOOT_IM_SELECT_BIT  16

`endif

//--- verilog/boot_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module boot_fsm import boot_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ready,
    input  logic      rd_valid,
    input  logic      tx_done,
    load_ctl_if.fsm   ctl,
    output host_op_t  op,
    output logic      running,
    output logic      dm_load_en,
    output logic      im_load_en
);

    boot_state_t state, next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CPU_IDLE;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////
    // transitions
    //////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            CPU_IDLE: begin
                if (ready) next_state = WAIT_INIT_DM;
            end
            WAIT_INIT_DM: begin
                if (rd_valid) next_state = INIT_DM;   // word 0 arrives
            end
            INIT_DM: begin
                if (tx_done) begin
                    // last data block hands over to the instruction image
                    next_state = ctl.last_block ? WAIT_INIT_IM : WAIT_INIT_DM;
                end
            end
            WAIT_INIT_IM: begin
                if (rd_valid) next_state = INIT_IM;
            end
            INIT_IM: begin
                if (tx_done) begin
                    next_state = ctl.last_block ? RUN : WAIT_INIT_IM;
                end
            end
            RUN: begin
                next_state = RUN;       // until reset
            end
            default: begin
                next_state = CPU_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // decoded controls
    //////////////////////////////////////////////////
    logic wait_st, init_st;

    assign wait_st = (state == WAIT_INIT_DM) || (state == WAIT_INIT_IM);
    assign init_st = (state == INIT_DM) || (state == INIT_IM);

    assign ctl.loading    = wait_st || init_st;
    assign ctl.im_phase   = (state == WAIT_INIT_IM) || (state == INIT_IM);
    assign ctl.first_word = wait_st;
    assign ctl.step       = init_st;
    assign ctl.next_block = init_st && tx_done && !ctl.last_block;

    assign op      = ctl.loading ? READ : IDLE;
    assign running = (state == RUN);

    // word 0 on rd_valid, then one word per INIT cycle
    assign dm_load_en = ((state == WAIT_INIT_DM) && rd_valid) || (state == INIT_DM);
    assign im_load_en = ((state == WAIT_INIT_IM) && rd_valid) || (state == INIT_IM);

    // word 0 only answers a READ request still waiting for data
    a_valid_in_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid |-> ((op == READ) && wait_st)
    );

    // tx_done closes a block already in transfer
    a_done_in_init: assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_done |-> init_st
    );

endmodule

`default_nettype wire

//--- verilog/boot_ifs.sv
`timescale 1ns/10ps
`default_nettype none

//////////////////////////////////////////////////
// loader control, fsm to block counter
//////////////////////////////////////////////////
interface load_ctl_if import boot_pkg::*; ();

    logic  loading;     // any of the four load states
    logic  im_phase;    // instruction image
    logic  first_word;  // waiting for word 0
    logic  step;        // one word per INIT cycle
    logic  next_block;
    logic  last_block;
    addr_t load_addr;   // memory write address

    modport fsm (
        output loading, im_phase, first_word, step, next_block,
        input  last_block
    );

    modport cnt (
        input  loading, im_phase, first_word, step, next_block,
        output last_block, load_addr
    );

endinterface

//////////////////////////////////////////////////
// accelerator port into the data memory
//////////////////////////////////////////////////
interface accel_if import boot_pkg::*; ();

    addr_t addr;
    word_t wrt_data;
    logic  wrt_en;
    logic  rd_en;
    logic  wrt_done;
    logic  rd_valid;
    line_t rd_data;     // whole 64-byte line

    modport host (
        output addr, wrt_data, wrt_en, rd_en,
        input  wrt_done, rd_valid, rd_data
    );

    modport mem (
        input  addr, wrt_data, wrt_en, rd_en,
        output wrt_done, rd_valid, rd_data
    );

endinterface

`default_nettype wire

//--- verilog/boot_pkg.sv
`default_nettype none

package boot_pkg;

    `include "boot_defs.svh"

    typedef logic [`BOOT_ADDR_W-1:0]                   addr_t;
    typedef logic [`BOOT_WORD_W-1:0]                   word_t;
    typedef logic [`BOOT_LINE_WORDS*`BOOT_WORD_W-1:0]  line_t;    // word 0 in the low bits
    typedef logic [`BOOT_EX_ADDR_W-1:0]                ex_addr_t;
    typedef logic [5:0]                                blk_idx_t;

    typedef enum logic [2:0] {
        CPU_IDLE,
        WAIT_INIT_DM,
        INIT_DM,
        WAIT_INIT_IM,
        INIT_IM,
        RUN
    } boot_state_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        READ = 2'b01
    } host_op_t;

    // data blocks 0..15 sit at 0x1000..0x4140 in pairs, block 16 at 0x0100
    function automatic addr_t dm_block_base(input blk_idx_t idx);
        addr_t base;
        base = '0;
        if (idx == blk_idx_t'(`BOOT_DM_BLOCKS - 1)) begin
            base = 16'h0100;
        end else begin
            base[15:12] = 4'(idx[3:2]) + 4'd1;  // 4 blocks per 4k page
            base[8]     = idx[1];
            base[6]     = idx[0];
        end
        return base;
    endfunction

    // instruction blocks are packed from address 0
    function automatic addr_t im_block_base(input blk_idx_t idx);
        return addr_t'(idx) << 6;
    endfunction

endpackage

`default_nettype wire

//--- verilog/boot_top.sv
`timescale 1ns/10ps
`default_nettype none

module boot_top import boot_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // host
    input  logic      ready,
    input  logic      rd_valid,
    input  logic      tx_done,
    input  word_t     ex_wrt_data,
    output host_op_t  op,
    output ex_addr_t  ex_addr,
    output logic      running,
    // fetch
    input  addr_t     fetch_addr,
    output word_t     fetch_instr,
    // accelerator
    input  addr_t     accel_addr,
    input  word_t     accel_wrt_data,
    input  logic      accel_wrt_en,
    input  logic      accel_rd_en,
    output logic      accel_wrt_done,
    output logic      accel_rd_valid,
    output line_t     accel_rd_data
);

    logic dm_load_en;
    logic im_load_en;

    load_ctl_if u_ctl_if ();
    accel_if    u_acc_if ();

    //////////////////////////////////////////////////
    // accelerator side of the data memory
    //////////////////////////////////////////////////
    assign u_acc_if.addr     = accel_addr;
    assign u_acc_if.wrt_data = accel_wrt_data;
    assign u_acc_if.wrt_en   = accel_wrt_en;
    assign u_acc_if.rd_en    = accel_rd_en;

    assign accel_wrt_done = u_acc_if.wrt_done;
    assign accel_rd_valid = u_acc_if.rd_valid;
    assign accel_rd_data  = u_acc_if.rd_data;

    boot_fsm u_boot_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready      (ready),
        .rd_valid   (rd_valid),
        .tx_done    (tx_done),
        .ctl        (u_ctl_if.fsm),
        .op         (op),
        .running    (running),
        .dm_load_en (dm_load_en),
        .im_load_en (im_load_en)
    );

    block_counter u_block_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctl     (u_ctl_if.cnt),
        .ex_addr (ex_addr)
    );

    // both memories take the host word at the same load address
    data_mem u_data_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (dm_load_en),
        .load_addr (u_ctl_if.load_addr),
        .load_data (ex_wrt_data),
        .running   (running),
        .acc       (u_acc_if.mem)
    );

    instr_mem u_instr_mem (
        .clk         (clk),
        .load_en     (im_load_en),
        .load_addr   (u_ctl_if.load_addr),
        .load_data   (ex_wrt_data),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr)
    );

endmodule

`default_nettype wire

//--- verilog/data_mem.sv
`timescale 1ns/10ps
`default_nettype none
`include "boot_defs.svh"

module data_mem import boot_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   load_en,
    input  addr_t  load_addr,
    input  word_t  load_data,
    input  logic   running,
    accel_if.mem   acc
);

    localparam int DM_WORDS = 1 << `BOOT_DM_INDEX_W;

    word_t mem [0:DM_WORDS-1];

    logic                          acc_wr;
    logic                          acc_rd;
    logic [`BOOT_DM_INDEX_W-1:0]   load_idx;
    logic [`BOOT_DM_INDEX_W-1:0]   acc_idx;
    logic [`BOOT_DM_INDEX_W-5:0]   line_idx;    // 64-byte line number

    // accelerator is locked out until the images are loaded
    assign acc_wr = acc.wrt_en && running;
    assign acc_rd = acc.rd_en && running;

    assign load_idx = load_addr[`BOOT_DM_INDEX_W+1:2];
    assign acc_idx  = acc.addr[`BOOT_DM_INDEX_W+1:2];
    assign line_idx = acc.addr[`BOOT_DM_INDEX_W+1:6];

    //////////////////////////////////////////////////
    // array and line read
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (acc_wr) begin
            mem[acc_idx] <= acc.wrt_data;
        end
        if (acc_rd) begin
            for (int i = 0; i < `BOOT_LINE_WORDS; i++) begin
                acc.rd_data[i*`BOOT_WORD_W +: `BOOT_WORD_W] <= mem[{line_idx, 4'(i)}];
            end
        end
    end

    // one-cycle response strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc.rd_valid <= 1'b0;
            acc.wrt_done <= 1'b0;
        end else begin
            acc.rd_valid <= acc_rd;
            acc.wrt_done <= acc_wr;
        end
    end

    // loader and accelerator never share the write port
    a_one_writer: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load_en && acc_wr)
    );

endmodule

`default_nettype wire

//--- verilog/instr_mem.sv
`timescale 1ns/10ps
`default_nettype none
`include "boot_defs.svh"

module instr_mem import boot_pkg::*; (
    input  logic   clk,
    input  logic   load_en,
    input  addr_t  load_addr,
    input  word_t  load_data,
    input  addr_t  fetch_addr,
    output word_t  fetch_instr
);

    localparam int IM_WORDS = 1 << `BOOT_IM_INDEX_W;

    word_t mem [0:IM_WORDS-1];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[`BOOT_IM_INDEX_W+1:2]] <= load_data;
        end
        fetch_instr <= mem[fetch_addr[`BOOT_IM_INDEX_W+1:2]];  // registered fetch
    end

    // loader addresses must be aligned and inside the array
    a_load_in_range: assert property (
        @(posedge clk)
        load_en |-> ((load_addr < addr_t'(IM_WORDS * 4)) && (load_addr[1:0] == 2'b00))
    );

endmodule

`default_nettype wire
